// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int DATA_W = 32;

  // alu operation codes
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_SLL  = 4'h2,
    ALU_SLT  = 4'h3,
    ALU_SLTU = 4'h4,
    ALU_XOR  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_OR   = 4'h8,
    ALU_AND  = 4'h9,
    ALU_LUI  = 4'ha
  } alu_cmd_t;

  // operand source kind
  typedef enum logic [1:0] {
    REG = 2'd0,
    IMM = 2'd1,
    PC  = 2'd2
  } op_type_t;

endpackage

`default_nettype wire

// File: iq_pkg.sv
`default_nettype none

package iq_pkg;

  localparam int TAG_W = 6;
  localparam int ROB_W = 5;
  localparam int LANES = 2;

  // true when any valid writeback lane carries this tag
  function automatic logic wb_hit(
    input logic [LANES-1:0]            valid,
    input logic [LANES-1:0][TAG_W-1:0] phys_rd,
    input logic [TAG_W-1:0]            tag
  );
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      hit = hit || (valid[l] && phys_rd[l] == tag);
    end
    return hit;
  endfunction

endpackage

`default_nettype wire

// File: dispatch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_decode (
  input  wire  [iq_pkg::LANES-1:0]                       disp_en,
  input  wire  isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]    disp_alu_cmd,
  input  wire  isa_pkg::op_type_t [iq_pkg::LANES-1:0]    disp_op1_type,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]    disp_op1_tag,
  input  wire  [iq_pkg::LANES-1:0]                       disp_op1_ready,
  input  wire  isa_pkg::op_type_t [iq_pkg::LANES-1:0]    disp_op2_type,
  input  wire  [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0]  disp_op2_data,
  input  wire  [iq_pkg::LANES-1:0]                       disp_op2_ready,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]    disp_phys_rd,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]    disp_rob_addr,
  input  wire  [iq_pkg::LANES-1:0]                       wb_valid,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]    wb_phys_rd,
  output logic [1:0]                                     pk_count,
  output isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]          pk_alu_cmd,
  output isa_pkg::op_type_t [iq_pkg::LANES-1:0]          pk_op1_type,
  output logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]    pk_op1,
  output isa_pkg::op_type_t [iq_pkg::LANES-1:0]          pk_op2_type,
  output logic [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0]  pk_op2,
  output logic [iq_pkg::LANES-1:0]                       pk_op1_ok,
  output logic [iq_pkg::LANES-1:0]                       pk_op2_ok,
  output logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]    pk_phys_rd,
  output logic [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]    pk_rob_addr
);

  always_comb begin
    int src;
    pk_count = 2'(disp_en[0]) + 2'(disp_en[1]);
    for (int l = 0; l < iq_pkg::LANES; l++) begin
      // lone lane 1 moves down into slot 0
      src = (l == 0 && !disp_en[0]) ? 1 : l;
      pk_alu_cmd[l]  = disp_alu_cmd[src];
      pk_op1_type[l] = disp_op1_type[src];
      pk_op1[l]      = disp_op1_tag[src];
      pk_op2_type[l] = disp_op2_type[src];
      pk_op2[l]      = disp_op2_data[src];
      pk_phys_rd[l]  = disp_phys_rd[src];
      pk_rob_addr[l] = disp_rob_addr[src];
      // non-register operands never wait
      pk_op1_ok[l] = (disp_op1_type[src] != isa_pkg::REG) || disp_op1_ready[src] ||
                     iq_pkg::wb_hit(wb_valid, wb_phys_rd, disp_op1_tag[src]);
      pk_op2_ok[l] = (disp_op2_type[src] != isa_pkg::REG) || disp_op2_ready[src] ||
                     iq_pkg::wb_hit(wb_valid, wb_phys_rd,
                                    disp_op2_data[src][iq_pkg::TAG_W-1:0]);
    end
  end

endmodule

`default_nettype wire

// File: issue_queue_store.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_store #(
  parameter int IQ_DEPTH = 8
) (
  input  wire                                             clk,
  input  wire                                             rst_n,
  input  wire                                             flush,
  input  wire  [1:0]                                      pk_count,
  input  wire  isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]     pk_alu_cmd,
  input  wire  isa_pkg::op_type_t [iq_pkg::LANES-1:0]     pk_op1_type,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     pk_op1,
  input  wire  isa_pkg::op_type_t [iq_pkg::LANES-1:0]     pk_op2_type,
  input  wire  [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0]   pk_op2,
  input  wire  [iq_pkg::LANES-1:0]                        pk_op1_ok,
  input  wire  [iq_pkg::LANES-1:0]                        pk_op2_ok,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     pk_phys_rd,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]     pk_rob_addr,
  input  wire  [iq_pkg::LANES-1:0]                        wb_valid,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     wb_phys_rd,
  input  wire  [1:0]                                      pick_count,
  input  wire  [iq_pkg::LANES-1:0][$clog2(IQ_DEPTH)-1:0]  pick_idx,
  output logic                                            full,
  output logic [IQ_DEPTH-1:0]                             entry_ready,
  output isa_pkg::alu_cmd_t [IQ_DEPTH-1:0]                q_alu_cmd,
  output isa_pkg::op_type_t [IQ_DEPTH-1:0]                q_op1_type,
  output logic [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]          q_op1,
  output isa_pkg::op_type_t [IQ_DEPTH-1:0]                q_op2_type,
  output logic [IQ_DEPTH-1:0][isa_pkg::DATA_W-1:0]        q_op2,
  output logic [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]          q_phys_rd,
  output logic [IQ_DEPTH-1:0][iq_pkg::ROB_W-1:0]          q_rob_addr
);

  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  logic [CNT_W-1:0]    tail;
  logic [CNT_W-1:0]    tail_keep;
  logic [CNT_W-1:0]    n_tail;
  logic [IQ_DEPTH-1:0] valid;
  logic [IQ_DEPTH-1:0] op1_ok;
  logic [IQ_DEPTH-1:0] op2_ok;
  logic [IQ_DEPTH-1:0] n_valid;
  logic [IQ_DEPTH-1:0] n_op1_ok;
  logic [IQ_DEPTH-1:0] n_op2_ok;

  isa_pkg::alu_cmd_t [IQ_DEPTH-1:0]          n_alu_cmd;
  isa_pkg::op_type_t [IQ_DEPTH-1:0]          n_op1_type;
  logic [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]    n_op1;
  isa_pkg::op_type_t [IQ_DEPTH-1:0]          n_op2_type;
  logic [IQ_DEPTH-1:0][isa_pkg::DATA_W-1:0]  n_op2;
  logic [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]    n_phys_rd;
  logic [IQ_DEPTH-1:0][iq_pkg::ROB_W-1:0]    n_rob_addr;

  assign entry_ready = valid & op1_ok & op2_ok;
  assign full        = tail > CNT_W'(IQ_DEPTH - 2);

  always_comb begin
    int src;
    tail_keep = tail - CNT_W'(pick_count);
    n_tail    = tail_keep + CNT_W'(pk_count);
    for (int i = 0; i < IQ_DEPTH; i++) begin
      // slot i pulls from i, i+1 or i+2 depending on picks below it
      src = i;
      if (pick_count != 2'd0 && i >= int'(pick_idx[0])) begin
        src = i + 1;
      end
      if (pick_count == 2'd2 && i >= int'(pick_idx[1]) - 1) begin
        src = i + 2;
      end
      n_valid[i]    = 1'b0;
      n_op1_ok[i]   = 1'b0;
      n_op2_ok[i]   = 1'b0;
      n_alu_cmd[i]  = q_alu_cmd[i];
      n_op1_type[i] = q_op1_type[i];
      n_op1[i]      = q_op1[i];
      n_op2_type[i] = q_op2_type[i];
      n_op2[i]      = q_op2[i];
      n_phys_rd[i]  = q_phys_rd[i];
      n_rob_addr[i] = q_rob_addr[i];
      if (src < IQ_DEPTH) begin
        n_valid[i]    = valid[src];
        n_alu_cmd[i]  = q_alu_cmd[src];
        n_op1_type[i] = q_op1_type[src];
        n_op1[i]      = q_op1[src];
        n_op2_type[i] = q_op2_type[src];
        n_op2[i]      = q_op2[src];
        n_phys_rd[i]  = q_phys_rd[src];
        n_rob_addr[i] = q_rob_addr[src];
        // wakeup while shifting
        n_op1_ok[i] = op1_ok[src] || (q_op1_type[src] == isa_pkg::REG &&
                      iq_pkg::wb_hit(wb_valid, wb_phys_rd, q_op1[src]));
        n_op2_ok[i] = op2_ok[src] || (q_op2_type[src] == isa_pkg::REG &&
                      iq_pkg::wb_hit(wb_valid, wb_phys_rd, q_op2[src][iq_pkg::TAG_W-1:0]));
      end
      // append packed dispatch behind the surviving entries
      for (int l = 0; l < iq_pkg::LANES; l++) begin
        if (l < int'(pk_count) && i == int'(tail_keep) + l) begin
          n_valid[i]    = 1'b1;
          n_op1_ok[i]   = pk_op1_ok[l];
          n_op2_ok[i]   = pk_op2_ok[l];
          n_alu_cmd[i]  = pk_alu_cmd[l];
          n_op1_type[i] = pk_op1_type[l];
          n_op1[i]      = pk_op1[l];
          n_op2_type[i] = pk_op2_type[l];
          n_op2[i]      = pk_op2[l];
          n_phys_rd[i]  = pk_phys_rd[l];
          n_rob_addr[i] = pk_rob_addr[l];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail   <= '0;
      valid  <= '0;
      op1_ok <= '0;
      op2_ok <= '0;
    end else if (flush) begin
      tail   <= '0;
      valid  <= '0;
      op1_ok <= '0;
      op2_ok <= '0;
    end else begin
      tail   <= n_tail;
      valid  <= n_valid;
      op1_ok <= n_op1_ok;
      op2_ok <= n_op2_ok;
    end
  end

  always_ff @(posedge clk) begin
    q_alu_cmd  <= n_alu_cmd;
    q_op1_type <= n_op1_type;
    q_op1      <= n_op1;
    q_op2_type <= n_op2_type;
    q_op2      <= n_op2;
    q_phys_rd  <= n_phys_rd;
    q_rob_addr <= n_rob_addr;
  end

  // producer must hold off while full
  a_no_disp_full: assert property (@(posedge clk) disable iff (!rst_n)
    full |-> pk_count == 2'd0);

  a_tail_range: assert property (@(posedge clk) disable iff (!rst_n)
    tail <= CNT_W'(IQ_DEPTH));

  // selector may only point at ready entries
  a_pick_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (pick_count != 2'd0 |-> entry_ready[pick_idx[0]]) and
    (pick_count == 2'd2 |-> entry_ready[pick_idx[1]]));

endmodule

`default_nettype wire

// File: issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select #(
  parameter int IQ_DEPTH = 8
) (
  input  wire                                             clk,
  input  wire                                             rst_n,
  input  wire                                             flush,
  input  wire  [IQ_DEPTH-1:0]                             entry_ready,
  input  wire  isa_pkg::alu_cmd_t [IQ_DEPTH-1:0]          q_alu_cmd,
  input  wire  isa_pkg::op_type_t [IQ_DEPTH-1:0]          q_op1_type,
  input  wire  [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]          q_op1,
  input  wire  isa_pkg::op_type_t [IQ_DEPTH-1:0]          q_op2_type,
  input  wire  [IQ_DEPTH-1:0][isa_pkg::DATA_W-1:0]        q_op2,
  input  wire  [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]          q_phys_rd,
  input  wire  [IQ_DEPTH-1:0][iq_pkg::ROB_W-1:0]          q_rob_addr,
  output logic [1:0]                                      pick_count,
  output logic [iq_pkg::LANES-1:0][$clog2(IQ_DEPTH)-1:0]  pick_idx,
  output logic [iq_pkg::LANES-1:0]                        issue_valid,
  output isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]           issue_alu_cmd,
  output isa_pkg::op_type_t [iq_pkg::LANES-1:0]           issue_op1_type,
  output logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     issue_op1,
  output isa_pkg::op_type_t [iq_pkg::LANES-1:0]           issue_op2_type,
  output logic [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0]   issue_op2,
  output logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     issue_phys_rd,
  output logic [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]     issue_rob_addr
);

  localparam int IDX_W = $clog2(IQ_DEPTH);

  // lowest index is oldest since the store stays compacted
  always_comb begin
    pick_count = 2'd0;
    pick_idx   = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (entry_ready[i] && pick_count != 2'd2) begin
        pick_idx[pick_count[0]] = IDX_W'(i);
        pick_count = pick_count + 2'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid <= '0;
    end else if (flush) begin
      issue_valid <= '0;
    end else begin
      issue_valid[0] <= pick_count != 2'd0;
      issue_valid[1] <= pick_count == 2'd2;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < iq_pkg::LANES; l++) begin
      issue_alu_cmd[l]  <= q_alu_cmd[pick_idx[l]];
      issue_op1_type[l] <= q_op1_type[pick_idx[l]];
      issue_op1[l]      <= q_op1[pick_idx[l]];
      issue_op2_type[l] <= q_op2_type[pick_idx[l]];
      issue_op2[l]      <= q_op2[pick_idx[l]];
      issue_phys_rd[l]  <= q_phys_rd[pick_idx[l]];
      issue_rob_addr[l] <= q_rob_addr[pick_idx[l]];
    end
  end

endmodule

`default_nettype wire

// File: issue_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_top #(
  parameter int IQ_DEPTH = 8
) (
  input  wire                                             clk,
  input  wire                                             rst_n,
  input  wire                                             flush,
  input  wire  [iq_pkg::LANES-1:0]                        disp_en,
  input  wire  isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]     disp_alu_cmd,
  input  wire  isa_pkg::op_type_t [iq_pkg::LANES-1:0]     disp_op1_type,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     disp_op1_tag,
  input  wire  [iq_pkg::LANES-1:0]                        disp_op1_ready,
  input  wire  isa_pkg::op_type_t [iq_pkg::LANES-1:0]     disp_op2_type,
  input  wire  [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0]   disp_op2_data,
  input  wire  [iq_pkg::LANES-1:0]                        disp_op2_ready,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     disp_phys_rd,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]     disp_rob_addr,
  output logic                                            full,
  input  wire  [iq_pkg::LANES-1:0]                        wb_valid,
  input  wire  [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     wb_phys_rd,
  output logic [iq_pkg::LANES-1:0]                        issue_valid,
  output isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]           issue_alu_cmd,
  output isa_pkg::op_type_t [iq_pkg::LANES-1:0]           issue_op1_type,
  output logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     issue_op1,
  output isa_pkg::op_type_t [iq_pkg::LANES-1:0]           issue_op2_type,
  output logic [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0]   issue_op2,
  output logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]     issue_phys_rd,
  output logic [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]     issue_rob_addr
);

  localparam int IDX_W = $clog2(IQ_DEPTH);

  // packed dispatch pair
  logic [1:0]                                   pk_count;
  isa_pkg::alu_cmd_t [iq_pkg::LANES-1:0]        pk_alu_cmd;
  isa_pkg::op_type_t [iq_pkg::LANES-1:0]        pk_op1_type;
  logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]  pk_op1;
  isa_pkg::op_type_t [iq_pkg::LANES-1:0]        pk_op2_type;
  logic [iq_pkg::LANES-1:0][isa_pkg::DATA_W-1:0] pk_op2;
  logic [iq_pkg::LANES-1:0]                     pk_op1_ok;
  logic [iq_pkg::LANES-1:0]                     pk_op2_ok;
  logic [iq_pkg::LANES-1:0][iq_pkg::TAG_W-1:0]  pk_phys_rd;
  logic [iq_pkg::LANES-1:0][iq_pkg::ROB_W-1:0]  pk_rob_addr;

  // queue contents toward the selector
  logic [IQ_DEPTH-1:0]                          entry_ready;
  isa_pkg::alu_cmd_t [IQ_DEPTH-1:0]             q_alu_cmd;
  isa_pkg::op_type_t [IQ_DEPTH-1:0]             q_op1_type;
  logic [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]       q_op1;
  isa_pkg::op_type_t [IQ_DEPTH-1:0]             q_op2_type;
  logic [IQ_DEPTH-1:0][isa_pkg::DATA_W-1:0]     q_op2;
  logic [IQ_DEPTH-1:0][iq_pkg::TAG_W-1:0]       q_phys_rd;
  logic [IQ_DEPTH-1:0][iq_pkg::ROB_W-1:0]       q_rob_addr;
  logic [1:0]                                   pick_count;
  logic [iq_pkg::LANES-1:0][IDX_W-1:0]          pick_idx;

  dispatch_decode u_decode (
    .disp_en, .disp_alu_cmd, .disp_op1_type, .disp_op1_tag, .disp_op1_ready,
    .disp_op2_type, .disp_op2_data, .disp_op2_ready, .disp_phys_rd, .disp_rob_addr,
    .wb_valid, .wb_phys_rd,
    .pk_count, .pk_alu_cmd, .pk_op1_type, .pk_op1, .pk_op2_type, .pk_op2,
    .pk_op1_ok, .pk_op2_ok, .pk_phys_rd, .pk_rob_addr
  );

  issue_queue_store #(.IQ_DEPTH(IQ_DEPTH)) u_store (
    .clk, .rst_n, .flush,
    .pk_count, .pk_alu_cmd, .pk_op1_type, .pk_op1, .pk_op2_type, .pk_op2,
    .pk_op1_ok, .pk_op2_ok, .pk_phys_rd, .pk_rob_addr,
    .wb_valid, .wb_phys_rd, .pick_count, .pick_idx,
    .full, .entry_ready, .q_alu_cmd, .q_op1_type, .q_op1, .q_op2_type, .q_op2,
    .q_phys_rd, .q_rob_addr
  );

  issue_select #(.IQ_DEPTH(IQ_DEPTH)) u_select (
    .clk, .rst_n, .flush, .entry_ready,
    .q_alu_cmd, .q_op1_type, .q_op1, .q_op2_type, .q_op2, .q_phys_rd, .q_rob_addr,
    .pick_count, .pick_idx,
    .issue_valid, .issue_alu_cmd, .issue_op1_type, .issue_op1, .issue_op2_type,
    .issue_op2, .issue_phys_rd, .issue_rob_addr
  );

endmodule

`default_nettype wire

// File: tb_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_queue;

  localparam int IQ_DEPTH = 8;
  localparam int N_OPS    = 200;
  localparam int LIMIT    = N_OPS * 6 + 100;

  logic clk;
  logic rst_n;
  logic flush;
  logic [1:0]                        disp_en;
  isa_pkg::alu_cmd_t [1:0]           disp_alu_cmd;
  isa_pkg::op_type_t [1:0]           disp_op1_type;
  logic [1:0][iq_pkg::TAG_W-1:0]     disp_op1_tag;
  logic [1:0]                        disp_op1_ready;
  isa_pkg::op_type_t [1:0]           disp_op2_type;
  logic [1:0][isa_pkg::DATA_W-1:0]   disp_op2_data;
  logic [1:0]                        disp_op2_ready;
  logic [1:0][iq_pkg::TAG_W-1:0]     disp_phys_rd;
  logic [1:0][iq_pkg::ROB_W-1:0]     disp_rob_addr;
  logic                              full;
  logic [1:0]                        wb_valid;
  logic [1:0][iq_pkg::TAG_W-1:0]     wb_phys_rd;
  logic [1:0]                        issue_valid;
  isa_pkg::alu_cmd_t [1:0]           issue_alu_cmd;
  isa_pkg::op_type_t [1:0]           issue_op1_type;
  logic [1:0][iq_pkg::TAG_W-1:0]     issue_op1;
  isa_pkg::op_type_t [1:0]           issue_op2_type;
  logic [1:0][isa_pkg::DATA_W-1:0]   issue_op2;
  logic [1:0][iq_pkg::TAG_W-1:0]     issue_phys_rd;
  logic [1:0][iq_pkg::ROB_W-1:0]     issue_rob_addr;

  // reference table indexed by rob address
  logic        t_valid [32];
  int          t_seq   [32];
  logic [3:0]  t_alu   [32];
  logic [1:0]  t_ty1   [32];
  logic [1:0]  t_ty2   [32];
  logic [5:0]  t_op1   [32];
  logic [31:0] t_op2   [32];
  logic [5:0]  t_rd    [32];
  logic        t_ok1   [32];
  logic        t_ok2   [32];

  logic [31:0] lfsr = 32'd36;
  logic [5:0]  wait_tags[$];
  int errors = 0;
  int cycles = 0;
  int pend_cnt, in_q, seq_ctr, disp_cnt, issued_cnt, flushed_cnt;
  logic [4:0] next_rob;
  logic       flush_done;

  logic        exp_live [2];
  logic        exp_rdy  [2];
  int          exp_seq  [2];
  logic [3:0]  exp_alu  [2];
  logic [1:0]  exp_ty1  [2];
  logic [1:0]  exp_ty2  [2];
  logic [5:0]  exp_op1  [2];
  logic [31:0] exp_op2  [2];
  logic [5:0]  exp_rd   [2];
  logic        solo;
  logic [4:0]  solo_rob;

  issue_queue_top #(.IQ_DEPTH(IQ_DEPTH)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic wb_match(input logic [5:0] tag);
    return (wb_valid[0] && wb_phys_rd[0] == tag) || (wb_valid[1] && wb_phys_rd[1] == tag);
  endfunction

  // ready if non-register, flagged ready or written back this cycle
  function automatic logic rule_ok(input isa_pkg::op_type_t ty, input logic rdy,
                                   input logic [5:0] tag);
    return ty != isa_pkg::REG || rdy || wb_match(tag);
  endfunction

  task automatic get_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
  endtask

  task automatic fill_lane(input int l, input bit easy);
    logic [31:0] r;
    get_bits(4, r);
    disp_alu_cmd[l] = isa_pkg::alu_cmd_t'(r % 11);
    get_bits(2, r);
    disp_op1_type[l] = (easy || r == 3) ? isa_pkg::PC : isa_pkg::REG;
    get_bits(1, r);
    disp_op1_ready[l] = easy | r[0];
    get_bits(6, r);
    disp_op1_tag[l] = r[5:0];
    get_bits(2, r);
    disp_op2_type[l] = (easy || r == 3) ? isa_pkg::IMM : isa_pkg::REG;
    get_bits(1, r);
    disp_op2_ready[l] = easy | r[0];
    get_bits(32, r);
    disp_op2_data[l] = r;
    get_bits(6, r);
    disp_phys_rd[l] = r[5:0];
    disp_rob_addr[l] = next_rob;
    next_rob = next_rob + 5'd1;
    if (disp_op1_type[l] == isa_pkg::REG && !disp_op1_ready[l]) begin
      wait_tags.push_back(disp_op1_tag[l]);
    end
    if (disp_op2_type[l] == isa_pkg::REG && !disp_op2_ready[l]) begin
      wait_tags.push_back(disp_op2_data[l][5:0]);
    end
    disp_en[l] = 1'b1;
    disp_cnt++;
  endtask

  // one negedge worth of dispatch and writeback
  task automatic drive_cycle(input bit easy);
    logic [31:0] r;
    disp_en  = '0;
    wb_valid = '0;
    if (easy) begin
      fill_lane(0, 1'b1);
    end else if (!full && disp_cnt < N_OPS) begin
      get_bits(2, r);
      if (r[0]) fill_lane(0, 1'b0);
      if (r[1] && disp_cnt < N_OPS) fill_lane(1, 1'b0);
    end
    for (int l = 0; l < 2; l++) begin
      get_bits(1, r);
      if (r[0] && wait_tags.size() > 0) begin
        wb_valid[l]   = 1'b1;
        wb_phys_rd[l] = wait_tags.pop_front();
      end
    end
  endtask

  // reference bookkeeping at each rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n || flush) begin
      if (rst_n) begin
        flushed_cnt += pend_cnt - int'(issue_valid[0]) - int'(issue_valid[1]);
        issued_cnt  += int'(issue_valid[0]) + int'(issue_valid[1]);
      end
      for (int r = 0; r < 32; r++) t_valid[r] = 1'b0;
      pend_cnt = 0;
    end else begin
      for (int l = 0; l < 2; l++) begin
        if (issue_valid[l]) begin
          t_valid[issue_rob_addr[l]] = 1'b0;
          pend_cnt--;
          issued_cnt++;
        end
      end
      for (int r = 0; r < 32; r++) begin
        if (t_valid[r] && t_ty1[r] == isa_pkg::REG && wb_match(t_op1[r])) t_ok1[r] = 1'b1;
        if (t_valid[r] && t_ty2[r] == isa_pkg::REG && wb_match(t_op2[r][5:0])) t_ok2[r] = 1'b1;
      end
      for (int l = 0; l < 2; l++) begin
        if (disp_en[l]) begin
          t_valid[disp_rob_addr[l]] = 1'b1;
          t_seq[disp_rob_addr[l]]   = seq_ctr;
          t_alu[disp_rob_addr[l]]   = disp_alu_cmd[l];
          t_ty1[disp_rob_addr[l]]   = disp_op1_type[l];
          t_ty2[disp_rob_addr[l]]   = disp_op2_type[l];
          t_op1[disp_rob_addr[l]]   = disp_op1_tag[l];
          t_op2[disp_rob_addr[l]]   = disp_op2_data[l];
          t_rd[disp_rob_addr[l]]    = disp_phys_rd[l];
          t_ok1[disp_rob_addr[l]]   = rule_ok(disp_op1_type[l], disp_op1_ready[l],
                                              disp_op1_tag[l]);
          t_ok2[disp_rob_addr[l]]   = rule_ok(disp_op2_type[l], disp_op2_ready[l],
                                              disp_op2_data[l][5:0]);
          seq_ctr++;
          pend_cnt++;
        end
      end
    end
  end

  always_comb begin
    for (int l = 0; l < 2; l++) begin
      exp_live[l] = t_valid[issue_rob_addr[l]];
      exp_rdy[l]  = t_ok1[issue_rob_addr[l]] && t_ok2[issue_rob_addr[l]];
      exp_seq[l]  = t_seq[issue_rob_addr[l]];
      exp_alu[l]  = t_alu[issue_rob_addr[l]];
      exp_ty1[l]  = t_ty1[issue_rob_addr[l]];
      exp_ty2[l]  = t_ty2[issue_rob_addr[l]];
      exp_op1[l]  = t_op1[issue_rob_addr[l]];
      exp_op2[l]  = t_op2[issue_rob_addr[l]];
      exp_rd[l]   = t_rd[issue_rob_addr[l]];
    end
    // entries still held by the queue itself
    in_q = pend_cnt - int'(issue_valid[0]) - int'(issue_valid[1]);
    solo = in_q == 0 && !flush && (disp_en == 2'b01 || disp_en == 2'b10) &&
           rule_ok(disp_op1_type[disp_en[1]], disp_op1_ready[disp_en[1]],
                   disp_op1_tag[disp_en[1]]) &&
           rule_ok(disp_op2_type[disp_en[1]], disp_op2_ready[disp_en[1]],
                   disp_op2_data[disp_en[1]][5:0]);
    solo_rob = disp_rob_addr[disp_en[1]];
  end

  for (genvar l = 0; l < 2; l++) begin : g_lane
    a_live: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid[l] |-> exp_live[l]) else begin
      errors++;
      $display("t=%0t lane %0d issued rob %0d which is not pending", $time, l,
               $sampled(issue_rob_addr[l]));
    end
    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid[l] |-> exp_rdy[l]) else begin
      errors++;
      $display("t=%0t lane %0d issued rob %0d before its operands were ready", $time, l,
               $sampled(issue_rob_addr[l]));
    end
    a_alu: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid[l] |-> issue_alu_cmd[l] == exp_alu[l]) else begin
      errors++;
      $display("CHECK FAILED t=%0t issue_alu_cmd[%0d] exp=%0h act=%0h", $time, l,
               $sampled(exp_alu[l]), $sampled(issue_alu_cmd[l]));
    end
    a_ops: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid[l] |-> issue_op1[l] == exp_op1[l] && issue_op2[l] == exp_op2[l]) else begin
      errors++;
      $display("CHECK FAILED t=%0t issue_op1/op2[%0d] exp=%0h/%0h act=%0h/%0h", $time, l,
               $sampled(exp_op1[l]), $sampled(exp_op2[l]),
               $sampled(issue_op1[l]), $sampled(issue_op2[l]));
    end
    a_types: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid[l] |-> issue_op1_type[l] == exp_ty1[l] && issue_op2_type[l] == exp_ty2[l])
      else begin
      errors++;
      $display("CHECK FAILED t=%0t issue_op1/op2_type[%0d] exp=%0d/%0d act=%0d/%0d", $time, l,
               $sampled(exp_ty1[l]), $sampled(exp_ty2[l]),
               $sampled(issue_op1_type[l]), $sampled(issue_op2_type[l]));
    end
    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid[l] |-> issue_phys_rd[l] == exp_rd[l]) else begin
      errors++;
      $display("CHECK FAILED t=%0t issue_phys_rd[%0d] exp=%0h act=%0h", $time, l,
               $sampled(exp_rd[l]), $sampled(issue_phys_rd[l]));
    end
  end

  a_order: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[1] |-> issue_valid[0] && exp_seq[0] < exp_seq[1]) else begin
    errors++;
    $display("t=%0t lane 1 valid alone or younger than lane 0", $time);
  end
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    pend_cnt == 0 |-> issue_valid == 2'b00) else begin
    errors++;
    $display("t=%0t issue with nothing pending", $time);
  end
  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> issue_valid == 2'b00 && !full) else begin
    errors++;
    $display("t=%0t queue not empty after flush", $time);
  end
  a_full: assert property (@(posedge clk) disable iff (!rst_n)
    full == (in_q > IQ_DEPTH - 2)) else begin
    errors++;
    $display("CHECK FAILED t=%0t full exp=%0d act=%0d", $time,
             $sampled(in_q > IQ_DEPTH - 2), $sampled(full));
  end
  // one ready op into an empty queue issues two edges after sampling
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    solo ##1 !flush |-> ##1 (issue_valid[0] && issue_rob_addr[0] == $past(solo_rob, 2)))
    else begin
    errors++;
    $display("t=%0t single ready dispatch missed its issue slot", $time);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    disp_en = '0;
    disp_alu_cmd = '{default: isa_pkg::ALU_ADD};
    disp_op1_type = '{default: isa_pkg::REG};
    disp_op2_type = '{default: isa_pkg::REG};
    disp_op1_tag = '0;
    disp_op1_ready = '0;
    disp_op2_data = '0;
    disp_op2_ready = '0;
    disp_phys_rd = '0;
    disp_rob_addr = '0;
    wb_valid = '0;
    wb_phys_rd = '0;
    next_rob = '0;
    flush_done = 1'b0;
    seq_ctr = 0;
    disp_cnt = 0;
    issued_cnt = 0;
    flushed_cnt = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    drive_cycle(1'b1);
    while (disp_cnt < N_OPS) begin
      @(negedge clk);
      if (!flush_done && disp_cnt >= N_OPS / 2) begin
        flush_done = 1'b1;
        disp_en  = '0;
        wb_valid = '0;
        flush    = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_tags.delete();
        drive_cycle(1'b1);
      end else begin
        drive_cycle(1'b0);
      end
    end
    do begin
      @(negedge clk);
      drive_cycle(1'b0);
    end while (pend_cnt != 0);
    repeat (3) @(negedge clk);
    $display("errors: %0d  dispatched: %0d  issued: %0d  flushed: %0d",
             errors, disp_cnt, issued_cnt, flushed_cnt);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
isa_pkg.sv
iq_pkg.sv
dispatch_decode.sv
issue_queue_store.sv
issue_select.sv
issue_queue_top.sv
tb_issue_queue.sv

// File: run_sim.sh
#!/bin/sh
# build and run the issue queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_issue_queue -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log \
  && grep -qx "Test OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
